// File: verilog/exec_core_settings.svh
`ifndef EXEC_CORE_SETTINGS_SVH
`define EXEC_CORE_SETTINGS_SVH

// datapath word, also instruction and counter width
`define EXEC_DATA_W 32

// register file geometry
`define EXEC_NUM_REGS 32
`define EXEC_REG_IDX_W 5

// apb address bus width
`define EXEC_APB_ADDR_W 12

// write issues an instruction, read returns the retired count
`define EXEC_INSTR_OFFSET 12'h000

// register n sits at base + 4n
`define EXEC_REG_WINDOW 12'h080

`endif

// File: verilog/exec_core_pkg.sv
`include "exec_core_settings.svh"

package exec_core_pkg;

    // data, instruction and counter words
    typedef logic [`EXEC_DATA_W-1:0] word_t;

    // register number
    typedef logic [`EXEC_REG_IDX_W-1:0] reg_idx_t;

    // raw 16-bit immediate field of an i-type word
    typedef logic [15:0] imm_t;

    // shift amount field
    typedef logic [4:0] shamt_t;

    // alu operations
    // add and sub both wrap, no overflow trap
    typedef enum logic [3:0] {
        op_add,
        op_sub,
        op_and,
        op_or,
        op_xor,
        op_nor,
        op_slt,
        op_sltu,
        op_sll,
        op_srl,
        op_sra,
        op_lui
    } alu_op_t;

    // apb port fsm
    // execute is the single wait state of an instruction write
    typedef enum logic {
        st_idle,
        st_execute
    } apb_state_t;

endpackage

// File: verilog/regfile.sv
`include "exec_core_settings.svh"

module regfile import exec_core_pkg::*; (
    input  logic     r_clk,
    input  logic     reset,
    input  logic     r_clk_enable,
    // write strobe, qualified by r_clk_enable
    input  logic     write_control,
    // two independent read ports
    input  reg_idx_t read_reg1,
    input  reg_idx_t read_reg2,
    // write port
    input  reg_idx_t write_reg,
    input  word_t    write_data,
    output word_t    read_data1,
    output word_t    read_data2
);

    word_t registers [`EXEC_NUM_REGS];

    always_ff @(posedge r_clk) begin
        if (reset) begin
            for (int i = 0; i < `EXEC_NUM_REGS; i++) begin
                registers[i] <= '0;
            end
        end else if (r_clk_enable && write_control && (write_reg != '0)) begin
            // register 0 never written, so it reads zero forever
            registers[write_reg] <= write_data;
        end
    end

    // combinational reads
    assign read_data1 = registers[read_reg1];
    assign read_data2 = registers[read_reg2];

endmodule

// File: verilog/instr_decoder.sv
module instr_decoder import exec_core_pkg::*; (
    input  word_t    instr,
    output reg_idx_t rs,
    output reg_idx_t rt,
    output reg_idx_t rd_dest,
    output imm_t     imm,
    output shamt_t   shamt,
    output alu_op_t  alu_op,
    output logic     use_imm,
    output logic     imm_signed,
    output logic     illegal
);

    // mips opcodes
    localparam logic [5:0] opc_special = 6'h00;
    localparam logic [5:0] opc_addiu   = 6'h09;
    localparam logic [5:0] opc_slti    = 6'h0a;
    localparam logic [5:0] opc_sltiu   = 6'h0b;
    localparam logic [5:0] opc_andi    = 6'h0c;
    localparam logic [5:0] opc_ori     = 6'h0d;
    localparam logic [5:0] opc_xori    = 6'h0e;
    localparam logic [5:0] opc_lui     = 6'h0f;

    // r-type function codes
    localparam logic [5:0] fn_sll  = 6'h00;
    localparam logic [5:0] fn_srl  = 6'h02;
    localparam logic [5:0] fn_sra  = 6'h03;
    localparam logic [5:0] fn_add  = 6'h20;
    localparam logic [5:0] fn_addu = 6'h21;
    localparam logic [5:0] fn_sub  = 6'h22;
    localparam logic [5:0] fn_subu = 6'h23;
    localparam logic [5:0] fn_and  = 6'h24;
    localparam logic [5:0] fn_or   = 6'h25;
    localparam logic [5:0] fn_xor  = 6'h26;
    localparam logic [5:0] fn_nor  = 6'h27;
    localparam logic [5:0] fn_slt  = 6'h2a;
    localparam logic [5:0] fn_sltu = 6'h2b;

    logic [5:0] opcode;
    logic [5:0] funct;

    // fixed field positions
    assign opcode = instr[31:26];
    assign funct  = instr[5:0];
    assign rs     = instr[25:21];
    assign rt     = instr[20:16];
    assign imm    = instr[15:0];
    assign shamt  = instr[10:6];

    always_comb begin
        // r-type defaults, rd field is the destination
        rd_dest    = instr[15:11];
        alu_op     = op_add;
        use_imm    = 1'b0;
        imm_signed = 1'b0;
        illegal    = 1'b0;
        if (opcode == opc_special) begin
            case (funct)
                fn_sll:          alu_op = op_sll;
                fn_srl:          alu_op = op_srl;
                fn_sra:          alu_op = op_sra;
                // no overflow trap, add behaves as addu
                fn_add, fn_addu: alu_op = op_add;
                fn_sub, fn_subu: alu_op = op_sub;
                fn_and:          alu_op = op_and;
                fn_or:           alu_op = op_or;
                fn_xor:          alu_op = op_xor;
                fn_nor:          alu_op = op_nor;
                fn_slt:          alu_op = op_slt;
                fn_sltu:         alu_op = op_sltu;
                default:         illegal = 1'b1;
            endcase
        end else begin
            // i-type writes the rt field
            rd_dest = instr[20:16];
            use_imm = 1'b1;
            case (opcode)
                opc_addiu: begin
                    alu_op     = op_add;
                    imm_signed = 1'b1;
                end
                opc_slti: begin
                    alu_op     = op_slt;
                    imm_signed = 1'b1;
                end
                // sign-extended, then compared unsigned
                opc_sltiu: begin
                    alu_op     = op_sltu;
                    imm_signed = 1'b1;
                end
                opc_andi: alu_op = op_and;
                opc_ori:  alu_op = op_or;
                opc_xori: alu_op = op_xor;
                opc_lui:  alu_op = op_lui;
                default:  illegal = 1'b1;
            endcase
        end
    end

endmodule

// File: verilog/alu.sv
module alu import exec_core_pkg::*; (
    input  alu_op_t alu_op,
    // rs operand
    input  word_t   op_a,
    // rt operand, also the shift source
    input  word_t   op_b,
    input  imm_t    imm,
    input  logic    use_imm,
    input  logic    imm_signed,
    input  shamt_t  shamt,
    output word_t   result
);

    localparam int ext_w = $bits(word_t) - $bits(imm_t);

    word_t imm_ext;
    word_t operand_b;

    // sign or zero extension of the immediate
    assign imm_ext = imm_signed ? {{ext_w{imm[15]}}, imm} : {{ext_w{1'b0}}, imm};

    // second operand mux
    assign operand_b = use_imm ? imm_ext : op_b;

    always_comb begin
        case (alu_op)
            // wrapping arithmetic
            op_add:  result = op_a + operand_b;
            op_sub:  result = op_a - operand_b;
            // bitwise logic
            op_and:  result = op_a & operand_b;
            op_or:   result = op_a | operand_b;
            op_xor:  result = op_a ^ operand_b;
            op_nor:  result = ~(op_a | operand_b);
            // compares yield 0 or 1
            op_slt:  result = word_t'($signed(op_a) < $signed(operand_b));
            op_sltu: result = word_t'(op_a < operand_b);
            // shifts always act on rt
            op_sll:  result = op_b << shamt;
            op_srl:  result = op_b >> shamt;
            op_sra:  result = word_t'($signed(op_b) >>> shamt);
            // immediate into the upper half
            op_lui:  result = {imm, {ext_w{1'b0}}};
            default: result = '0;
        endcase
    end

endmodule

// File: verilog/apb_exec_port.sv
`include "exec_core_settings.svh"

module apb_exec_port import exec_core_pkg::*; (
    input  logic                        r_clk,
    input  logic                        reset,
    input  logic                        psel,
    input  logic                        penable,
    input  logic                        pwrite,
    input  logic [`EXEC_APB_ADDR_W-1:0] paddr,
    input  word_t                       pwdata,
    output word_t                       prdata,
    output logic                        pready,
    output logic                        pslverr,
    // latched instruction to the decoder
    output word_t                       instr,
    input  reg_idx_t                    rs,
    input  logic                        illegal,
    // register file read port 1
    output reg_idx_t                    read_sel,
    input  word_t                       read_data,
    output logic                        r_clk_enable,
    output logic                        write_control
);

    apb_state_t                  state;
    word_t                       instr_q;
    word_t                       retired;
    logic                        access;
    logic                        instr_hit;
    logic                        win_hit;
    logic                        start_exec;
    logic [`EXEC_APB_ADDR_W-1:0] win_offset;

    // address map decode
    assign access     = psel && penable;
    assign instr_hit  = (paddr == `EXEC_INSTR_OFFSET);
    assign win_offset = paddr - `EXEC_REG_WINDOW;
    // below the base the offset wraps high and misses
    assign win_hit    = (win_offset < 4 * `EXEC_NUM_REGS) && (win_offset[1:0] == 2'b00);
    assign start_exec = (state == st_idle) && access && pwrite && instr_hit;

    always_ff @(posedge r_clk) begin
        if (reset) begin
            state   <= st_idle;
            retired <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (start_exec) begin
                        state <= st_execute;
                    end
                end
                st_execute: begin
                    // result lands in the regfile on this same edge
                    state <= st_idle;
                    if (!illegal) begin
                        retired <= retired + 1'b1;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // instruction latch
    always_ff @(posedge r_clk) begin
        if (start_exec) begin
            instr_q <= pwdata;
        end
    end

    always_comb begin
        pready  = 1'b0;
        pslverr = 1'b0;
        prdata  = '0;
        if (state == st_execute) begin
            pready  = 1'b1;
            pslverr = illegal;
        end else if (access && !start_exec) begin
            // zero wait state accesses
            pready = 1'b1;
            if (!pwrite && instr_hit) begin
                prdata = retired;
            end else if (!pwrite && win_hit) begin
                prdata = read_data;
            end else begin
                pslverr = 1'b1;
            end
        end
    end

    // port 1 serves rs while executing, the window otherwise
    assign read_sel      = (state == st_execute) ? rs : win_offset[`EXEC_REG_IDX_W+1:2];
    assign instr         = instr_q;
    assign r_clk_enable  = (state == st_execute);
    assign write_control = (state == st_execute) && !illegal;

endmodule

// File: verilog/exec_core_top.sv
`include "exec_core_settings.svh"

module exec_core_top import exec_core_pkg::*; (
    input  logic                        r_clk,
    input  logic                        reset,
    // apb slave
    input  logic                        psel,
    input  logic                        penable,
    input  logic                        pwrite,
    input  logic [`EXEC_APB_ADDR_W-1:0] paddr,
    input  word_t                       pwdata,
    output word_t                       prdata,
    output logic                        pready,
    output logic                        pslverr
);

    // port to decoder
    word_t    instr;
    logic     illegal;
    // decoder fields
    reg_idx_t rs;
    reg_idx_t rt;
    reg_idx_t rd_dest;
    imm_t     imm;
    shamt_t   shamt;
    alu_op_t  alu_op;
    logic     use_imm;
    logic     imm_signed;
    // register file controls and data
    reg_idx_t read_sel;
    logic     r_clk_enable;
    logic     write_control;
    word_t    read_data1;
    word_t    read_data2;
    word_t    result;

    apb_exec_port u_apb_exec_port (
        .r_clk         (r_clk),
        .reset         (reset),
        .psel          (psel),
        .penable       (penable),
        .pwrite        (pwrite),
        .paddr         (paddr),
        .pwdata        (pwdata),
        .prdata        (prdata),
        .pready        (pready),
        .pslverr       (pslverr),
        .instr         (instr),
        .rs            (rs),
        .illegal       (illegal),
        .read_sel      (read_sel),
        .read_data     (read_data1),
        .r_clk_enable  (r_clk_enable),
        .write_control (write_control)
    );

    instr_decoder u_instr_decoder (
        .instr      (instr),
        .rs         (rs),
        .rt         (rt),
        .rd_dest    (rd_dest),
        .imm        (imm),
        .shamt      (shamt),
        .alu_op     (alu_op),
        .use_imm    (use_imm),
        .imm_signed (imm_signed),
        .illegal    (illegal)
    );

    alu u_alu (
        .alu_op     (alu_op),
        .op_a       (read_data1),
        .op_b       (read_data2),
        .imm        (imm),
        .use_imm    (use_imm),
        .imm_signed (imm_signed),
        .shamt      (shamt),
        .result     (result)
    );

    regfile u_regfile (
        .r_clk         (r_clk),
        .reset         (reset),
        .r_clk_enable  (r_clk_enable),
        .write_control (write_control),
        .read_reg1     (read_sel),
        .read_reg2     (rt),
        .write_reg     (rd_dest),
        .write_data    (result),
        .read_data1    (read_data1),
        .read_data2    (read_data2)
    );

endmodule

// File: dv/exec_core_tb.sv
`include "exec_core_settings.svh"

module exec_core_tb import exec_core_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    typedef logic [`EXEC_APB_ADDR_W-1:0] addr_t;

    localparam int clk_period   = 10;
    localparam int half_period  = clk_period / 2;
    // sample 1 ns ahead of the rising edge
    localparam int sample_delay = half_period - 1;
    localparam int n_random     = 200;
    localparam int n_bus_err    = 24;
    // two sweeps, write plus two reads per instruction, error accesses, r0 test
    localparam int num_transfers = 2 * (`EXEC_NUM_REGS + 1) + 3 * n_random + n_bus_err + 4;
    localparam int watchdog_ns   = num_transfers * 4 * clk_period * 2;

    // legal r-type function codes
    localparam logic [5:0] r_functs [13] = '{
        6'h00, 6'h02, 6'h03, 6'h20, 6'h21, 6'h22, 6'h23,
        6'h24, 6'h25, 6'h26, 6'h27, 6'h2a, 6'h2b
    };

    logic  r_clk;
    logic  reset;
    logic  psel;
    logic  penable;
    logic  pwrite;
    addr_t paddr;
    word_t pwdata;
    word_t prdata;
    logic  pready;
    logic  pslverr;

    // reference model state
    word_t model_regs [`EXEC_NUM_REGS];
    word_t model_retired;

    exec_core_top u_exec_core_top (
        .r_clk   (r_clk),
        .reset   (reset),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    initial begin
        r_clk = 1'b0;
        forever #(half_period) r_clk = ~r_clk;
    end

    // hard limit on run time
    initial begin
        #(watchdog_ns);
        $display("Simulation timed out before the test sequence finished");
        $display("Test failed");
        $fatal(1, "watchdog expired");
    end

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        if (expected !== actual) begin
            $display("Error: %s expected %h actual %h", name, expected, actual);
            $display("Test failed");
            $fatal(1, "word mismatch");
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (expected !== actual) begin
            $display("Error: %s expected %b actual %b", name, expected, actual);
            $display("Test failed");
            $fatal(1, "flag mismatch");
        end
    endtask

    // one apb transfer, waits counts access cycles with pready low
    task automatic bus_transfer(input logic write, input addr_t addr, input word_t wdata,
                                output word_t rdata, output logic err, output int waits);
        @(negedge r_clk);
        // setup phase
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge r_clk);
        penable = 1'b1;
        waits   = 0;
        #(sample_delay);
        while (!pready) begin
            waits++;
            @(negedge r_clk);
            #(sample_delay);
        end
        rdata = prdata;
        err   = pslverr;
        // release after the completing edge
        @(negedge r_clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input addr_t addr, input word_t wdata,
                             output logic err, output int waits);
        word_t unused_rdata;
        bus_transfer(1'b1, addr, wdata, unused_rdata, err, waits);
    endtask

    task automatic apb_read(input addr_t addr, output word_t rdata,
                            output logic err, output int waits);
        bus_transfer(1'b0, addr, '0, rdata, err, waits);
    endtask

    function automatic addr_t window_addr(input reg_idx_t idx);
        window_addr = addr_t'(`EXEC_REG_WINDOW + 4 * idx);
    endfunction

    // true for addresses that a read would hit
    function automatic logic is_mapped(input addr_t addr);
        int a;
        a = int'(addr);
        is_mapped = (a == `EXEC_INSTR_OFFSET) ||
                    ((a >= `EXEC_REG_WINDOW) && (a < `EXEC_REG_WINDOW + 4 * `EXEC_NUM_REGS) &&
                     (a % 4 == 0));
    endfunction

    // mips semantics, returns 0 for an encoding outside the supported set
    function automatic logic predict_result(input word_t ins, output reg_idx_t dest,
                                            output word_t value);
        word_t a;
        word_t b;
        word_t se;
        word_t ze;
        imm_t  im;
        int    sh;
        a  = model_regs[ins[25:21]];
        b  = model_regs[ins[20:16]];
        im = ins[15:0];
        sh = int'(ins[10:6]);
        se = {{16{im[15]}}, im};
        ze = {16'h0000, im};
        // i-type default, rt receives the result
        dest  = ins[20:16];
        value = '0;
        predict_result = 1'b1;
        case (ins[31:26])
            6'h00: begin
                dest = ins[15:11];
                case (ins[5:0])
                    6'h00:        value = b << sh;
                    6'h02:        value = b >> sh;
                    6'h03:        value = word_t'($signed(b) >>> sh);
                    6'h20, 6'h21: value = a + b;
                    6'h22, 6'h23: value = a - b;
                    6'h24:        value = a & b;
                    6'h25:        value = a | b;
                    6'h26:        value = a ^ b;
                    6'h27:        value = ~(a | b);
                    6'h2a:        value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    6'h2b:        value = (a < b) ? 32'd1 : 32'd0;
                    default:      predict_result = 1'b0;
                endcase
            end
            6'h09:   value = a + se;
            6'h0a:   value = ($signed(a) < $signed(se)) ? 32'd1 : 32'd0;
            // sltiu compares the sign-extended immediate as unsigned
            6'h0b:   value = (a < se) ? 32'd1 : 32'd0;
            6'h0c:   value = a & ze;
            6'h0d:   value = a | ze;
            6'h0e:   value = a ^ ze;
            6'h0f:   value = {im, 16'h0000};
            default: predict_result = 1'b0;
        endcase
    endfunction

    task automatic verify_reg(input reg_idx_t idx, input string tag);
        word_t rdata;
        logic  err;
        int    waits;
        apb_read(window_addr(idx), rdata, err, waits);
        check_word($sformatf("%s r%0d", tag, idx), model_regs[idx], rdata);
        check_flag($sformatf("%s r%0d pslverr", tag, idx), 1'b0, err);
        check_word($sformatf("%s r%0d read waits", tag, idx), '0, word_t'(waits));
    endtask

    task automatic verify_counter(input string tag);
        word_t rdata;
        logic  err;
        int    waits;
        apb_read(`EXEC_INSTR_OFFSET, rdata, err, waits);
        check_word({tag, " retired count"}, model_retired, rdata);
        check_flag({tag, " counter pslverr"}, 1'b0, err);
        check_word({tag, " counter read waits"}, '0, word_t'(waits));
    endtask

    task automatic verify_all(input string tag);
        for (int i = 0; i < `EXEC_NUM_REGS; i++) begin
            verify_reg(reg_idx_t'(i), tag);
        end
        verify_counter(tag);
    endtask

    // issue one instruction, update the model, read back dest and counter
    task automatic run_instr(input word_t ins, input string tag);
        reg_idx_t dest;
        word_t    value;
        logic     legal;
        logic     err;
        int       waits;
        legal = predict_result(ins, dest, value);
        apb_write(`EXEC_INSTR_OFFSET, ins, err, waits);
        check_word({tag, " instr waits"}, 32'd1, word_t'(waits));
        check_flag({tag, " instr pslverr"}, !legal, err);
        if (legal) begin
            // r0 is hardwired
            if (dest != '0) begin
                model_regs[dest] = value;
            end
            model_retired = model_retired + 32'd1;
        end
        verify_reg(dest, tag);
        verify_counter(tag);
    endtask

    function automatic word_t random_instr();
        word_t    ins;
        reg_idx_t dest;
        word_t    value;
        int       kind;
        logic [5:0] fn;
        kind = $urandom_range(9);
        if (kind < 4) begin
            fn  = r_functs[$urandom_range(12)];
            ins = {6'h00, reg_idx_t'($urandom), reg_idx_t'($urandom),
                   reg_idx_t'($urandom), 5'd0, fn};
            // shamt only for the shifts
            if (fn <= 6'h03) begin
                ins[10:6] = shamt_t'($urandom);
            end
        end else if (kind < 8) begin
            ins = {6'(9 + $urandom_range(6)), reg_idx_t'($urandom),
                   reg_idx_t'($urandom), imm_t'($urandom)};
        end else begin
            ins = $urandom;
            while (predict_result(ins, dest, value)) begin
                ins = $urandom;
            end
        end
        random_instr = ins;
    endfunction

    initial begin
        word_t ins;
        addr_t addr;
        logic  wr;
        logic  err;
        word_t rdata;
        int    waits;
        reset   = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        void'($urandom(32'h0935_acad));
        for (int i = 0; i < `EXEC_NUM_REGS; i++) begin
            model_regs[i] = '0;
        end
        model_retired = '0;
        repeat (4) @(negedge r_clk);
        reset = 1'b0;

        verify_all("reset");

        // addiu r0, r0, 0x1234 retires but r0 stays zero
        run_instr({6'h09, 5'd0, 5'd0, 16'h1234}, "r0 target");

        for (int i = 0; i < n_random; i++) begin
            ins = random_instr();
            run_instr(ins, $sformatf("instr %0d (%h)", i, ins));
        end

        // window writes and unmapped accesses
        for (int i = 0; i < n_bus_err; i++) begin
            if ($urandom_range(1) == 1) begin
                addr = window_addr(reg_idx_t'($urandom));
                wr   = 1'b1;
            end else begin
                addr = addr_t'($urandom);
                while (is_mapped(addr)) begin
                    addr = addr_t'($urandom);
                end
                wr = 1'($urandom_range(1));
            end
            bus_transfer(wr, addr, $urandom, rdata, err, waits);
            check_flag($sformatf("bus error %0d at %h pslverr", i, addr), 1'b1, err);
            check_word($sformatf("bus error %0d at %h waits", i, addr), '0, word_t'(waits));
        end

        verify_all("final");

        $display("Test passed");
        $finish;
    end

endmodule

// File: flist.f
+incdir+verilog
verilog/exec_core_pkg.sv
verilog/regfile.sv
verilog/instr_decoder.sv
verilog/alu.sv
verilog/apb_exec_port.sv
verilog/exec_core_top.sv
dv/exec_core_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the exec core testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module exec_core_tb -f flist.f -o exec_core_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/exec_core_sim 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "Test passed"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1
